/* dispatch_pkg.sv */
package dispatch_pkg;

    // width of the functional-unit busy vector, indexed by fu_t - 1
    localparam int N_FU = 5;

    typedef enum logic [6:0] {
        OP_ALU    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_BRANCH = 7'b1100011,
        OP_MLOAD  = 7'b0000111,
        OP_GEMM   = 7'b1110111
    } opcode_t;

    // scalar view of an instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } s_instr_t;

    // matrix view, ms3 overlaps the scalar rs1 field
    typedef struct packed {
        logic [3:0] md;
        logic [3:0] ms1;
        logic [3:0] ms2;
        logic [3:0] ms3;
        logic [8:0] imm9;
        opcode_t    opcode;
    } m_instr_t;

    typedef union packed {
        s_instr_t s;
        m_instr_t m;
    } instr_u;

    typedef enum logic [2:0] {
        FU_NONE     = 3'd0,
        FU_S_ALU    = 3'd1,
        FU_S_LD_ST  = 3'd2,
        FU_S_BRANCH = 3'd3,
        FU_M_LD_ST  = 3'd4,
        FU_M_GEMM   = 3'd5
    } fu_t;

    // producer tag of a source operand
    typedef logic [1:0] tag_t;

    localparam tag_t TAG_READY = 2'd0;
    localparam tag_t TAG_EXEC  = 2'd1;
    localparam tag_t TAG_LOAD  = 2'd2;

    typedef struct packed {
        logic busy;
        tag_t tag;
        logic spec;
    } rst_entry_t;

    typedef struct packed {
        logic       s_en;
        logic [4:0] s_reg;
        logic       m_en;
        logic [3:0] m_reg;
    } wb_t;

    typedef struct packed {
        logic        valid;
        fu_t         fu;
        logic [4:0]  rd;
        logic [4:0]  src1;
        logic [4:0]  src2;
        logic [4:0]  src3;
        tag_t        tag1;
        tag_t        tag2;
        tag_t        tag3;
        logic [11:0] imm;
        logic        spec;
    } issue_t;

endpackage

/* instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder import dispatch_pkg::*; (
    input  instr_u      instr,
    output fu_t         fu,
    output logic        s_write,
    output logic        m_write,
    output logic [11:0] imm
);

    logic [11:0] s_imm;
    logic [11:0] m_imm;

    // scalar immediate sits in the upper bits of the word
    assign s_imm = {instr.s.funct7, instr.s.rs2};

    // matrix load offset, sign extended to the issue width
    assign m_imm = {{3{instr.m.imm9[8]}}, instr.m.imm9};

    always_comb begin
        fu      = FU_NONE;
        s_write = 1'b0;
        m_write = 1'b0;
        imm     = '0;
        case (instr.s.opcode)
            OP_ALU: begin
                fu      = FU_S_ALU;
                s_write = 1'b1;
                imm     = s_imm;
            end
            OP_LOAD: begin
                fu      = FU_S_LD_ST;
                s_write = 1'b1;
                imm     = s_imm;
            end
            OP_BRANCH: begin
                // no destination, only the offset
                fu  = FU_S_BRANCH;
                imm = s_imm;
            end
            OP_MLOAD: begin
                fu      = FU_M_LD_ST;
                m_write = 1'b1;
                imm     = m_imm;
            end
            OP_GEMM: begin
                fu      = FU_M_GEMM;
                m_write = 1'b1;
            end
            default: begin
                // unknown opcode decodes as a no-op
                fu = FU_NONE;
            end
        endcase
    end

endmodule

/* reg_status_table.sv */
`timescale 1ns/10ps

module reg_status_table import dispatch_pkg::*; #(
    parameter int NREGS = 32
) (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       di_write,
    input  logic [$clog2(NREGS)-1:0]   di_sel,
    input  tag_t                       di_tag,
    input  logic                       di_spec,
    input  logic                       wb_write,
    input  logic [$clog2(NREGS)-1:0]   wb_sel,
    input  logic                       spec_clear,
    output rst_entry_t [NREGS-1:0]     status
);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            status <= '0;
        end else begin
            // branch miss squashes everything written under speculation
            if (spec_clear) begin
                for (int i = 0; i < NREGS; i++) begin
                    if (status[i].spec) begin
                        status[i] <= '0;
                    end
                end
            end
            if (wb_write) begin
                status[wb_sel] <= '0;
            end
            // later assignment wins, so a new producer overrides the writeback
            if (di_write) begin
                status[di_sel].busy <= 1'b1;
                status[di_sel].tag  <= di_tag;
                status[di_sel].spec <= di_spec;
            end
        end
    end

endmodule

/* instr_fetch.sv */
`timescale 1ns/10ps

module instr_fetch import dispatch_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        CLK,
    input  logic        nRST,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic [31:0] wb_adr,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        take,
    output logic        buf_valid,
    output instr_u      buf_instr
);

    logic [31:0] pc;
    logic        discard;
    logic        start;
    logic        fill;

    // classic single read, strobe follows the cycle
    assign wb_stb = wb_cyc;

    // open a new cycle only into an empty buffer
    assign start = ~wb_cyc & ~buf_valid & ~redirect;

    // word returned after a redirect belongs to the old path
    assign fill = wb_cyc & wb_ack & ~discard & ~redirect;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc        <= RESET_PC;
            wb_cyc    <= 1'b0;
            buf_valid <= 1'b0;
            discard   <= 1'b0;
        end else begin
            if (start) begin
                wb_cyc <= 1'b1;
            end else if (wb_cyc && wb_ack) begin
                wb_cyc <= 1'b0;
            end

            // wb_adr keeps the old address while the open cycle finishes
            if (redirect) begin
                pc <= redirect_pc;
            end else if (fill) begin
                pc <= pc + 32'd4;
            end

            if (wb_cyc && wb_ack) begin
                discard <= 1'b0;
            end else if (wb_cyc && redirect) begin
                discard <= 1'b1;
            end

            if (redirect) begin
                buf_valid <= 1'b0;
            end else if (fill) begin
                buf_valid <= 1'b1;
            end else if (take) begin
                buf_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            wb_adr <= pc;
        end
        if (fill) begin
            buf_instr <= wb_dat_i;
        end
    end

endmodule

/* dispatch.sv */
`timescale 1ns/10ps

module dispatch import dispatch_pkg::*; #(
    parameter int S_REGS = 32,
    parameter int M_REGS = 16
) (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            buf_valid,
    input  instr_u          buf_instr,
    output logic            take,
    input  logic            flush,
    input  logic [N_FU-1:0] fu_busy,
    input  wb_t             wb,
    input  logic            branch_resolved,
    input  logic            branch_miss,
    output issue_t          issue
);

    fu_t                     fu;
    logic                    s_write;
    logic                    m_write;
    logic [11:0]             imm;
    logic                    unit_busy;
    logic                    waw;
    logic                    hazard;
    logic                    accept;
    logic                    spec;
    logic                    s_di_write;
    logic                    m_di_write;
    tag_t                    s_tag;
    tag_t                    m_tag;
    rst_entry_t [S_REGS-1:0] s_status;
    rst_entry_t [M_REGS-1:0] m_status;
    issue_t                  n_issue;

    instr_decoder u_decoder (
        .instr   (buf_instr),
        .fu      (fu),
        .s_write (s_write),
        .m_write (m_write),
        .imm     (imm)
    );

    // structural hazard on the decoded unit
    assign unit_busy = (fu != FU_NONE) ? fu_busy[int'(fu) - 1] : 1'b0;

    // WAW against the table that the instruction writes
    assign waw = (s_write & s_status[buf_instr.s.rd].busy)
               | (m_write & m_status[buf_instr.m.md].busy);

    assign hazard = unit_busy | waw;
    assign accept = buf_valid & ~flush & ~hazard;
    // a flush drops the buffered word even under a hazard
    assign take   = buf_valid & (flush | ~hazard);

    // x0 is hardwired and never becomes pending
    assign s_di_write = accept & s_write & (buf_instr.s.rd != 5'd0);
    assign m_di_write = accept & m_write;
    assign s_tag      = (fu == FU_S_LD_ST) ? TAG_LOAD : TAG_EXEC;
    assign m_tag      = (fu == FU_M_LD_ST) ? TAG_LOAD : TAG_EXEC;

    reg_status_table #(.NREGS(S_REGS)) u_s_table (
        .CLK        (CLK),
        .nRST       (nRST),
        .di_write   (s_di_write),
        .di_sel     (buf_instr.s.rd),
        .di_tag     (s_tag),
        .di_spec    (spec),
        .wb_write   (wb.s_en),
        .wb_sel     (wb.s_reg),
        .spec_clear (branch_miss),
        .status     (s_status)
    );

    reg_status_table #(.NREGS(M_REGS)) u_m_table (
        .CLK        (CLK),
        .nRST       (nRST),
        .di_write   (m_di_write),
        .di_sel     (buf_instr.m.md),
        .di_tag     (m_tag),
        .di_spec    (spec),
        .wb_write   (wb.m_en),
        .wb_sel     (wb.m_reg),
        .spec_clear (branch_miss),
        .status     (m_status)
    );

    always_comb begin
        n_issue       = '0;
        n_issue.valid = accept & (fu != FU_NONE);
        n_issue.fu    = fu;
        n_issue.imm   = imm;
        n_issue.spec  = spec;
        if (fu == FU_M_GEMM) begin
            n_issue.rd   = {1'b0, buf_instr.m.md};
            n_issue.src1 = {1'b0, buf_instr.m.ms1};
            n_issue.src2 = {1'b0, buf_instr.m.ms2};
            n_issue.src3 = {1'b0, buf_instr.m.ms3};
            n_issue.tag1 = m_status[buf_instr.m.ms1].tag;
            n_issue.tag2 = m_status[buf_instr.m.ms2].tag;
            n_issue.tag3 = m_status[buf_instr.m.ms3].tag;
        end else if (fu == FU_M_LD_ST) begin
            // base address comes from the scalar side
            n_issue.rd   = {1'b0, buf_instr.m.md};
            n_issue.src1 = buf_instr.s.rs1;
            n_issue.tag1 = s_status[buf_instr.s.rs1].tag;
        end else if (fu != FU_NONE) begin
            n_issue.rd   = buf_instr.s.rd;
            n_issue.src1 = buf_instr.s.rs1;
            n_issue.src2 = buf_instr.s.rs2;
            n_issue.tag1 = s_status[buf_instr.s.rs1].tag;
            n_issue.tag2 = s_status[buf_instr.s.rs2].tag;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            issue <= '0;
            spec  <= 1'b0;
        end else begin
            issue <= n_issue;
            // everything after a dispatched branch runs speculatively
            if (accept && fu == FU_S_BRANCH) begin
                spec <= 1'b1;
            end else if (branch_resolved || branch_miss) begin
                spec <= 1'b0;
            end
        end
    end

endmodule

/* dispatch_top.sv */
`timescale 1ns/10ps

module dispatch_top import dispatch_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0000_1000,
    parameter int          S_REGS   = 32,
    parameter int          M_REGS   = 16
) (
    input  logic            CLK,
    input  logic            nRST,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic [31:0]     wb_adr,
    input  logic [31:0]     wb_dat_i,
    input  logic            wb_ack,
    input  logic            redirect,
    input  logic [31:0]     redirect_pc,
    input  logic [N_FU-1:0] fu_busy,
    input  wb_t             wb,
    input  logic            branch_resolved,
    input  logic            branch_miss,
    output issue_t          issue
);

    logic   buf_valid;
    instr_u buf_instr;
    logic   take;

    instr_fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .CLK         (CLK),
        .nRST        (nRST),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .take        (take),
        .buf_valid   (buf_valid),
        .buf_instr   (buf_instr)
    );

    // a redirect also flushes the word waiting in dispatch
    dispatch #(.S_REGS(S_REGS), .M_REGS(M_REGS)) u_dispatch (
        .CLK             (CLK),
        .nRST            (nRST),
        .buf_valid       (buf_valid),
        .buf_instr       (buf_instr),
        .take            (take),
        .flush           (redirect),
        .fu_busy         (fu_busy),
        .wb              (wb),
        .branch_resolved (branch_resolved),
        .branch_miss     (branch_miss),
        .issue           (issue)
    );

endmodule

/* tb_dispatch_assertions.sv */
`timescale 1ns/10ps

module tb_dispatch_assertions import dispatch_pkg::*; (
    input logic            CLK,
    input logic            nRST,
    input logic            wb_cyc,
    input logic            wb_stb,
    input logic [31:0]     wb_adr,
    input logic            wb_ack,
    input logic [N_FU-1:0] fu_busy,
    input issue_t          issue
);

    // the master closes the bus cycle right after the acknowledge
    cyc_ends: assert property (@(posedge CLK) disable iff (!nRST)
        wb_cyc && wb_ack |=> !wb_cyc && !wb_stb)
        else $error("wishbone cycle still open after ack");

    // request and address hold until the slave acknowledges
    req_held: assert property (@(posedge CLK) disable iff (!nRST)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
        else $error("wishbone request dropped or address changed before ack");

    // with every unit busy nothing issues
    no_issue_busy: assert property (@(posedge CLK) disable iff (!nRST)
        (&fu_busy) |=> !issue.valid)
        else $error("issue valid while all units were busy");

endmodule

bind dispatch_top tb_dispatch_assertions u_assertions (.*);

/* tb_dispatch.sv */
`timescale 1ns/10ps

module tb_dispatch import dispatch_pkg::*;;

    localparam logic [31:0] RESET_PC = 32'h0000_1000;
    localparam int          TIMEOUT  = 200;

    logic            CLK;
    logic            nRST;
    logic            wb_cyc;
    logic            wb_stb;
    logic [31:0]     wb_adr;
    logic [31:0]     wb_dat_i;
    logic            wb_ack;
    logic            redirect;
    logic [31:0]     redirect_pc;
    logic [N_FU-1:0] fu_busy;
    wb_t             wb;
    logic            branch_resolved;
    logic            branch_miss;
    issue_t          issue;

    // instruction memory behind the wishbone slave model
    logic [31:0] mem [0:1023];
    logic        in_cycle;
    int          wait_cnt;
    issue_t      iss_q [$];
    logic [31:0] adr_q [$];
    int          n_fail = 0;
    int          n_timeout = 0;

    dispatch_top #(.RESET_PC(RESET_PC), .S_REGS(32), .M_REGS(16)) DUT (
        .CLK             (CLK),
        .nRST            (nRST),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_adr          (wb_adr),
        .wb_dat_i        (wb_dat_i),
        .wb_ack          (wb_ack),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .fu_busy         (fu_busy),
        .wb              (wb),
        .branch_resolved (branch_resolved),
        .branch_miss     (branch_miss),
        .issue           (issue)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // slave with 0 to 2 wait states, records the address of every new cycle
    always @(posedge CLK) begin
        #1;
        if (wb_ack) begin
            wb_ack   = 1'b0;
            in_cycle = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!in_cycle) begin
                in_cycle = 1'b1;
                wait_cnt = $urandom % 3;
                adr_q.push_back(wb_adr);
            end
            if (wait_cnt == 0) begin
                wb_ack   = 1'b1;
                wb_dat_i = mem[wb_adr[11:2]];
            end else begin
                wait_cnt--;
            end
        end
    end

    // issue records are sampled mid cycle
    always @(negedge CLK) begin
        if (nRST && issue.valid) begin
            iss_q.push_back(issue);
        end
    end

    function automatic logic [31:0] s_word(input opcode_t op, input int rd, input int rs1,
                                           input int rs2, input logic [6:0] f7);
        s_word = {f7, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), op};
    endfunction

    function automatic logic [31:0] m_word(input opcode_t op, input int md, input int ms1,
                                           input int ms2, input int ms3, input logic [8:0] imm9);
        m_word = {4'(md), 4'(ms1), 4'(ms2), 4'(ms3), imm9, op};
    endfunction

    // expected record from the instruction formats
    function automatic issue_t expect_issue(input logic [31:0] w, input logic spec,
                                            input tag_t t1, input tag_t t2, input tag_t t3);
        issue_t e;
        e       = '0;
        e.valid = 1'b1;
        e.spec  = spec;
        e.tag1  = t1;
        e.tag2  = t2;
        e.tag3  = t3;
        case (w[6:0])
            OP_MLOAD: begin
                // base register read through the scalar rs1 field
                e.fu   = FU_M_LD_ST;
                e.rd   = {1'b0, w[31:28]};
                e.src1 = w[19:15];
                e.imm  = {{3{w[15]}}, w[15:7]};
            end
            OP_GEMM: begin
                e.fu   = FU_M_GEMM;
                e.rd   = {1'b0, w[31:28]};
                e.src1 = {1'b0, w[27:24]};
                e.src2 = {1'b0, w[23:20]};
                e.src3 = {1'b0, w[19:16]};
            end
            default: begin
                e.fu   = (w[6:0] == OP_ALU) ? FU_S_ALU :
                         (w[6:0] == OP_LOAD) ? FU_S_LD_ST : FU_S_BRANCH;
                e.rd   = w[11:7];
                e.src1 = w[19:15];
                e.src2 = w[24:20];
                e.imm  = w[31:20];
            end
        endcase
        return e;
    endfunction

    task automatic check_issue(input string name, input issue_t exp, input issue_t act);
        if (exp !== act) begin
            n_fail++;
            $display("FAIL %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_tag(input string name, input tag_t exp, input tag_t act);
        if (exp !== act) begin
            n_fail++;
            $display("FAIL %s: expected tag %0d actual tag %0d", name, exp, act);
        end
    endtask

    task automatic check_adr(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            n_fail++;
            $display("FAIL %s: expected address %h actual address %h", name, exp, act);
        end
    endtask

    task automatic tick(input int n);
        repeat (n) begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic apply_reset();
        nRST = 1'b0;
        tick(10);
        nRST = 1'b1;
    endtask

    task automatic wait_issue(input string name, output issue_t rec);
        int n;
        n = 0;
        while (iss_q.size() == 0 && n < TIMEOUT) begin
            tick(1);
            n++;
        end
        if (iss_q.size() == 0) begin
            n_timeout++;
            $display("%s: no instruction issued within %0d cycles", name, TIMEOUT);
            rec = '0;
        end else begin
            rec = iss_q.pop_front();
        end
    endtask

    task automatic expect_quiet(input string name, input int n);
        tick(n);
        if (iss_q.size() != 0) begin
            n_fail++;
            $display("%s: an instruction issued while it should have stalled", name);
        end
    endtask

    task automatic start_at(input int idx);
        redirect    = 1'b1;
        redirect_pc = RESET_PC + 32'(idx * 4);
        tick(1);
        redirect = 1'b0;
        adr_q.delete();
    endtask

    task automatic writeback(input logic is_m, input int r);
        wb.s_en  = ~is_m;
        wb.s_reg = 5'(r);
        wb.m_en  = is_m;
        wb.m_reg = 4'(r);
        tick(1);
        wb = '0;
    endtask

    // empty both tables and leave speculation off
    task automatic retire_all();
        for (int i = 0; i < 32; i++) begin
            wb.s_en  = 1'b1;
            wb.s_reg = 5'(i);
            wb.m_en  = (i < 16);
            wb.m_reg = 4'(i);
            tick(1);
        end
        wb              = '0;
        branch_resolved = 1'b1;
        tick(1);
        branch_resolved = 1'b0;
    endtask

    task automatic test_alu_order();
        logic [31:0] w [4];
        issue_t      rec;
        for (int i = 0; i < 4; i++) begin
            w[i]   = s_word(OP_ALU, 10 + i, 1 + i, 5 + i, 7'(3 * i + 1));
            mem[i] = w[i];
        end
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            wait_issue("alu_order", rec);
            check_issue("alu_order", expect_issue(w[i], 1'b0, 2'd0, 2'd0, 2'd0), rec);
        end
        for (int i = 0; i < 4; i++) begin
            check_adr("alu_order", RESET_PC + 32'(4 * i), adr_q[i]);
        end
    endtask

    task automatic test_tags_writeback();
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        issue_t      rec;
        retire_all();
        w0      = s_word(OP_LOAD, 5, 1, 0, 7'h01);
        w1      = s_word(OP_ALU, 6, 5, 2, 7'h00);
        mem[64] = w0;
        mem[65] = w1;
        start_at(64);
        wait_issue("tags_load", rec);
        check_issue("tags_load", expect_issue(w0, 1'b0, 2'd0, 2'd0, 2'd0), rec);
        wait_issue("tags_after_load", rec);
        check_tag("tags_after_load", TAG_LOAD, rec.tag1);
        check_issue("tags_after_load", expect_issue(w1, 1'b0, TAG_LOAD, 2'd0, 2'd0), rec);
        writeback(1'b0, 5);
        // x5 is ready again, x6 still waits for the ALU
        w2      = s_word(OP_ALU, 7, 5, 6, 7'h00);
        mem[80] = w2;
        start_at(80);
        wait_issue("tags_after_wb", rec);
        check_tag("tags_after_wb", TAG_READY, rec.tag1);
        check_tag("tags_alu_src", TAG_EXEC, rec.tag2);
    endtask

    task automatic test_waw();
        logic [31:0] w0;
        logic [31:0] w1;
        issue_t      rec;
        retire_all();
        w0      = s_word(OP_ALU, 9, 1, 2, 7'h00);
        w1      = s_word(OP_ALU, 9, 3, 4, 7'h11);
        mem[96] = w0;
        mem[97] = w1;
        start_at(96);
        wait_issue("waw_first", rec);
        check_issue("waw_first", expect_issue(w0, 1'b0, 2'd0, 2'd0, 2'd0), rec);
        expect_quiet("waw_stall", 20);
        writeback(1'b0, 9);
        wait_issue("waw_second", rec);
        check_issue("waw_second", expect_issue(w1, 1'b0, 2'd0, 2'd0, 2'd0), rec);
    endtask

    task automatic test_structural();
        logic [31:0] w0;
        issue_t      rec;
        retire_all();
        w0       = s_word(OP_ALU, 12, 3, 4, 7'h2a);
        mem[128] = w0;
        fu_busy  = 5'b00001;
        start_at(128);
        expect_quiet("structural_stall", 20);
        fu_busy = '0;
        wait_issue("structural", rec);
        check_issue("structural", expect_issue(w0, 1'b0, 2'd0, 2'd0, 2'd0), rec);
    endtask

    task automatic test_matrix();
        logic [31:0] w [4];
        issue_t      rec;
        retire_all();
        w[0] = s_word(OP_LOAD, 7, 1, 0, 7'h00);
        // ms3 = 3 with imm9[8] set puts x7 in the scalar rs1 field
        w[1] = m_word(OP_MLOAD, 3, 0, 0, 3, 9'h104);
        w[2] = m_word(OP_GEMM, 4, 3, 1, 2, 9'h000);
        w[3] = m_word(OP_GEMM, 3, 1, 2, 5, 9'h000);
        for (int i = 0; i < 4; i++) begin
            mem[160 + i] = w[i];
        end
        start_at(160);
        wait_issue("matrix_base_load", rec);
        check_issue("matrix_base_load", expect_issue(w[0], 1'b0, 2'd0, 2'd0, 2'd0), rec);
        wait_issue("matrix_load", rec);
        check_tag("matrix_load", TAG_LOAD, rec.tag1);
        check_issue("matrix_load", expect_issue(w[1], 1'b0, TAG_LOAD, 2'd0, 2'd0), rec);
        wait_issue("matrix_gemm", rec);
        check_tag("matrix_gemm", TAG_LOAD, rec.tag1);
        check_issue("matrix_gemm", expect_issue(w[2], 1'b0, TAG_LOAD, 2'd0, 2'd0), rec);
        expect_quiet("matrix_waw_stall", 20);
        writeback(1'b1, 3);
        wait_issue("matrix_waw", rec);
        check_issue("matrix_waw", expect_issue(w[3], 1'b0, 2'd0, 2'd0, 2'd0), rec);
    endtask

    task automatic test_spec_flush();
        logic [31:0] w [4];
        issue_t      rec;
        retire_all();
        w[0] = s_word(OP_BRANCH, 0, 1, 2, 7'h04);
        w[1] = s_word(OP_ALU, 14, 1, 2, 7'h00);
        w[2] = s_word(OP_ALU, 15, 14, 1, 7'h00);
        w[3] = s_word(OP_ALU, 14, 1, 2, 7'h03);
        for (int i = 0; i < 3; i++) begin
            mem[192 + i] = w[i];
        end
        mem[208] = w[3];
        start_at(192);
        wait_issue("spec_branch", rec);
        check_issue("spec_branch", expect_issue(w[0], 1'b0, 2'd0, 2'd0, 2'd0), rec);
        wait_issue("spec_first", rec);
        check_issue("spec_first", expect_issue(w[1], 1'b1, 2'd0, 2'd0, 2'd0), rec);
        wait_issue("spec_second", rec);
        check_issue("spec_second", expect_issue(w[2], 1'b1, TAG_EXEC, 2'd0, 2'd0), rec);
        branch_miss = 1'b1;
        tick(1);
        branch_miss = 1'b0;
        // x14 was squashed, so the rewrite needs no writeback
        start_at(208);
        wait_issue("spec_rewrite", rec);
        check_issue("spec_rewrite", expect_issue(w[3], 1'b0, 2'd0, 2'd0, 2'd0), rec);

        // park an ALU word in the buffer with every unit busy, then redirect past it
        mem[224] = s_word(OP_ALU, 20, 1, 2, 7'h00);
        mem[240] = s_word(OP_LOAD, 21, 1, 0, 7'h05);
        fu_busy  = '1;
        start_at(224);
        tick(10);
        start_at(240);
        fu_busy = '0;
        wait_issue("flush", rec);
        check_issue("flush", expect_issue(mem[240], 1'b0, 2'd0, 2'd0, 2'd0), rec);
        check_adr("flush", RESET_PC + 32'(240 * 4), adr_q[0]);
    endtask

    initial begin
        nRST            = 1'b0;
        wb_dat_i        = '0;
        wb_ack          = 1'b0;
        redirect        = 1'b0;
        redirect_pc     = '0;
        fu_busy         = '0;
        wb              = '0;
        branch_resolved = 1'b0;
        branch_miss     = 1'b0;
        in_cycle        = 1'b0;
        wait_cnt        = 0;
        void'($urandom(32'h25c4));
        // no-op words, opcode 7'b0001011 is outside the ISA
        for (int i = 0; i < 1024; i++) begin
            mem[i] = {25'(i) ^ 25'h0a5a5a5, 7'b0001011};
        end

        test_alu_order();
        test_tags_writeback();
        test_waw();
        test_structural();
        test_matrix();
        test_spec_flush();
        tick(5);

        $display("checks done: %0d value errors, %0d timeouts", n_fail, n_timeout);
        if (n_fail == 0 && n_timeout == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
dispatch_pkg.sv
instr_decoder.sv
reg_status_table.sv
instr_fetch.sv
dispatch.sv
dispatch_top.sv
tb_dispatch_assertions.sv
tb_dispatch.sv

/* run.sh */
#!/bin/sh
# compile and run the dispatch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_dispatch -f all.f -o sim_tb_dispatch
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb_dispatch > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
exit 1
